// ==== verilog/noc_pkg.sv ====
`default_nettype none

package noc_pkg;

  // ========================================
  // network dimensions
  // ========================================

  localparam int num_ports = 4;
  localparam int port_w    = $clog2(num_ports);

  // injection timestamp and per-source sequence number
  localparam int ts_w   = 32;
  localparam int seq_w  = 16;
  localparam int data_w = seq_w + ts_w;

  typedef logic [port_w-1:0] port_idx_t;
  typedef logic [ts_w-1:0]   timestamp_t;

  // ========================================
  // packet format
  // ========================================

  // data[31:0] holds the injection timestamp, data[47:32] the sequence number
  typedef struct packed {
    logic              valid;
    port_idx_t         source;
    port_idx_t         dest;
    logic [data_w-1:0] data;
  } packet_t;

  // one packet slot per port
  typedef packet_t [num_ports-1:0] packet_vec_t;

endpackage

`default_nettype wire

// ==== verilog/stats_pkg.sv ====
`default_nettype none

package stats_pkg;

  import noc_pkg::*;

  // counter widths
  localparam int cnt_w    = 16;
  localparam int lat_w    = 24;
  localparam int total_w  = 32;
  localparam int result_w = 32;

  // ========================================
  // reader commands
  // ========================================

  typedef enum logic [2:0] {
    op_nop        = 3'd0,
    op_read_rx    = 3'd1,
    op_read_tx    = 3'd2,
    op_read_lat   = 3'd3,
    op_read_total = 3'd4,
    op_clear      = 3'd5
  } stat_op_t;

  typedef struct packed {
    stat_op_t  op;
    port_idx_t src;
    port_idx_t dst;
  } stat_cmd_t;

  // counters of one source/destination pair plus the global total
  typedef struct packed {
    logic [cnt_w-1:0]   rx_count;
    logic [cnt_w-1:0]   tx_count;
    logic [lat_w-1:0]   latency;
    logic [total_w-1:0] total_rx;
  } pair_stats_t;

endpackage

`default_nettype wire

// ==== verilog/traffic_gen.sv ====
`default_nettype none

module traffic_gen
  import noc_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst,
  input  logic [num_ports-1:0]      inject,
  input  port_idx_t [num_ports-1:0] inject_dest,
  input  logic [num_ports-1:0]      net_full,
  output packet_vec_t               pkt_tx,
  output timestamp_t                timestamp
);

  timestamp_t           ts_q;
  timestamp_t           ts_next;
  logic [seq_w-1:0]     seq_q [num_ports];
  logic [num_ports-1:0] accept;

  // a full port drops its inject strobe
  assign accept  = inject & ~net_full;
  assign ts_next = ts_q + 1'b1;

  assign timestamp = ts_q;

  // free-running cycle counter
  always_ff @(posedge clk) begin
    if (rst) begin
      ts_q <= '0;
    end else begin
      ts_q <= ts_next;
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < num_ports; i++) begin
      // stamp with the value that timestamp shows during the valid cycle
      pkt_tx[i].source <= port_idx_t'(i);
      pkt_tx[i].dest   <= inject_dest[i];
      pkt_tx[i].data   <= {seq_q[i], ts_next};

      if (rst) begin
        pkt_tx[i].valid <= 1'b0;
        seq_q[i]        <= '0;
      end else begin
        pkt_tx[i].valid <= accept[i];
        if (accept[i]) begin
          seq_q[i] <= seq_q[i] + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/crossbar.sv ====
`default_nettype none

module crossbar
  import noc_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  packet_vec_t          pkt_in,
  output packet_vec_t          pkt_out,
  output logic [num_ports-1:0] net_full
);

  packet_vec_t               buf_q;
  logic [num_ports-1:0]      buf_valid;
  packet_vec_t               req;
  logic [num_ports-1:0]      req_valid;
  logic [num_ports-1:0]      granted;
  logic [num_ports-1:0]      stall;
  logic [num_ports-1:0]      out_win;
  port_idx_t [num_ports-1:0] win_idx;
  port_idx_t [num_ports-1:0] rr_ptr;

  // ========================================
  // input side
  // ========================================

  // a waiting packet always goes before a fresh one
  always_comb begin
    for (int i = 0; i < num_ports; i++) begin
      req[i]       = buf_valid[i] ? buf_q[i] : pkt_in[i];
      req_valid[i] = buf_valid[i] | pkt_in[i].valid;
    end
  end

  // losers are held in the buffer for the next cycle
  assign stall = req_valid & ~granted;

  // full already in the cycle the buffer is being loaded, so the
  // generator cannot form a packet that would land on a full input
  assign net_full = stall;

  // ========================================
  // output arbitration
  // ========================================

  always_comb begin
    int idx;
    granted = '0;
    out_win = '0;
    win_idx = '0;
    for (int o = 0; o < num_ports; o++) begin
      // scan inputs starting at the round-robin pointer
      for (int k = 0; k < num_ports; k++) begin
        idx = (int'(rr_ptr[o]) + k) % num_ports;
        if (!out_win[o] && req_valid[idx] && req[idx].dest == port_idx_t'(o)) begin
          out_win[o]   = 1'b1;
          win_idx[o]   = port_idx_t'(idx);
          granted[idx] = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < num_ports; i++) begin
      if (stall[i]) begin
        buf_q[i] <= req[i];
      end
      pkt_out[i].source <= req[win_idx[i]].source;
      pkt_out[i].dest   <= req[win_idx[i]].dest;
      pkt_out[i].data   <= req[win_idx[i]].data;
    end

    if (rst) begin
      buf_valid <= '0;
      rr_ptr    <= '0;
      for (int o = 0; o < num_ports; o++) begin
        pkt_out[o].valid <= 1'b0;
      end
    end else begin
      buf_valid <= stall;
      for (int o = 0; o < num_ports; o++) begin
        pkt_out[o].valid <= out_win[o];
        // pointer moves one past the winner
        if (out_win[o]) begin
          rr_ptr[o] <= (win_idx[o] == port_idx_t'(num_ports - 1)) ? '0 : win_idx[o] + 1'b1;
        end
      end
    end
  end

  // generator must honour back-pressure
  for (genvar i = 0; i < num_ports; i++) begin : g_full_chk
    a_no_push_when_full: assert property (
      @(posedge clk) disable iff (rst) buf_valid[i] |-> !pkt_in[i].valid
    );
  end

endmodule

`default_nettype wire

// ==== verilog/packet_sink.sv ====
`default_nettype none

module packet_sink
  import noc_pkg::*;
  import stats_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        measure,
  input  logic        clear,
  input  packet_vec_t pkt_rx,
  input  packet_vec_t pkt_tx,
  input  timestamp_t  timestamp,
  input  port_idx_t   rd_src,
  input  port_idx_t   rd_dst,
  output pair_stats_t rd_stats
);

  // indexed [source][destination]
  logic [cnt_w-1:0]    rx_cnt [num_ports][num_ports];
  logic [cnt_w-1:0]    tx_cnt [num_ports][num_ports];
  logic [lat_w-1:0]    lat    [num_ports][num_ports];
  logic [total_w-1:0]  total;
  logic [lat_w-1:0]    lat_inc [num_ports];
  logic [port_w:0]     rx_num;
  logic                wrap;

  // ========================================
  // per-cycle increments
  // ========================================

  always_comb begin
    rx_num = '0;
    for (int k = 0; k < num_ports; k++) begin
      lat_inc[k] = lat_w'(timestamp - pkt_rx[k].data[ts_w-1:0]);
      if (pkt_rx[k].valid) begin
        rx_num = rx_num + 1'b1;
      end
    end
  end

  // ========================================
  // counters
  // ========================================

  always_ff @(posedge clk) begin
    if (rst || clear) begin
      total <= '0;
      for (int s = 0; s < num_ports; s++) begin
        for (int d = 0; d < num_ports; d++) begin
          rx_cnt[s][d] <= '0;
          tx_cnt[s][d] <= '0;
          lat[s][d]    <= '0;
        end
      end
    end else if (measure) begin
      total <= total + total_w'(rx_num);
      for (int k = 0; k < num_ports; k++) begin
        // receive side counts the arrival port as destination
        if (pkt_rx[k].valid) begin
          rx_cnt[pkt_rx[k].source][k] <= rx_cnt[pkt_rx[k].source][k] + 1'b1;
          lat[pkt_rx[k].source][k]    <= lat[pkt_rx[k].source][k] + lat_inc[k];
        end
        // transmit side counts the injecting port as source
        if (pkt_tx[k].valid) begin
          tx_cnt[k][pkt_tx[k].dest] <= tx_cnt[k][pkt_tx[k].dest] + 1'b1;
        end
      end
    end
  end

  assign rd_stats.rx_count = rx_cnt[rd_src][rd_dst];
  assign rd_stats.tx_count = tx_cnt[rd_src][rd_dst];
  assign rd_stats.latency  = lat[rd_src][rd_dst];
  assign rd_stats.total_rx = total;

  // ========================================
  // checks
  // ========================================

  // high when any counter would carry out this cycle
  always_comb begin
    logic [lat_w:0]   lat_sum;
    logic [total_w:0] total_sum;
    wrap = 1'b0;
    for (int k = 0; k < num_ports; k++) begin
      lat_sum = {1'b0, lat[pkt_rx[k].source][k]} + lat_inc[k];
      if (pkt_rx[k].valid && (rx_cnt[pkt_rx[k].source][k] == '1 || lat_sum[lat_w])) begin
        wrap = 1'b1;
      end
      if (pkt_tx[k].valid && tx_cnt[k][pkt_tx[k].dest] == '1) begin
        wrap = 1'b1;
      end
    end
    total_sum = {1'b0, total} + rx_num;
    if (total_sum[total_w]) begin
      wrap = 1'b1;
    end
  end

  a_no_wrap: assert property (
    @(posedge clk) disable iff (rst) (measure && !clear) |-> !wrap
  );

  // crossbar routing must deliver to the addressed port
  for (genvar k = 0; k < num_ports; k++) begin : g_dest_chk
    a_dest_match: assert property (
      @(posedge clk) disable iff (rst) pkt_rx[k].valid |-> pkt_rx[k].dest == port_idx_t'(k)
    );
  end

endmodule

`default_nettype wire

// ==== verilog/stat_reader.sv ====
`default_nettype none

module stat_reader
  import noc_pkg::*;
  import stats_pkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic                cmd_valid,
  input  stat_cmd_t           cmd,
  output port_idx_t           rd_src,
  output port_idx_t           rd_dst,
  output logic                clear,
  input  pair_stats_t         rd_stats,
  output logic                result_valid,
  output logic [result_w-1:0] result
);

  logic [result_w-1:0] sel;

  // pair address goes straight to the sink
  assign rd_src = cmd.src;
  assign rd_dst = cmd.dst;

  assign clear = cmd_valid && (cmd.op == op_clear);

  // ========================================
  // opcode decode
  // ========================================

  always_comb begin
    case (cmd.op)
      op_read_rx:    sel = result_w'(rd_stats.rx_count);
      op_read_tx:    sel = result_w'(rd_stats.tx_count);
      op_read_lat:   sel = result_w'(rd_stats.latency);
      op_read_total: sel = result_w'(rd_stats.total_rx);
      default:       sel = '0;
    endcase
  end

  // result stage
  always_ff @(posedge clk) begin
    if (cmd_valid) begin
      result <= sel;
    end
    if (rst) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= cmd_valid && (cmd.op != op_nop);
    end
  end

  a_legal_op: assert property (
    @(posedge clk) disable iff (rst)
      cmd_valid |-> cmd.op inside {op_nop, op_read_rx, op_read_tx, op_read_lat,
                                   op_read_total, op_clear}
  );

endmodule

`default_nettype wire

// ==== verilog/noc_meter_top.sv ====
`default_nettype none

module noc_meter_top
  import noc_pkg::*;
  import stats_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst,
  input  logic [num_ports-1:0]      inject,
  input  port_idx_t [num_ports-1:0] inject_dest,
  input  logic                      measure,
  input  logic                      cmd_valid,
  input  stat_cmd_t                 cmd,
  output logic [num_ports-1:0]      net_full,
  output logic                      result_valid,
  output logic [result_w-1:0]       result
);

  packet_vec_t pkt_tx;
  packet_vec_t pkt_rx;
  timestamp_t  timestamp;
  port_idx_t   rd_src;
  port_idx_t   rd_dst;
  logic        clear;
  pair_stats_t rd_stats;

  traffic_gen gen_i (
    .clk         (clk),
    .rst         (rst),
    .inject      (inject),
    .inject_dest (inject_dest),
    .net_full    (net_full),
    .pkt_tx      (pkt_tx),
    .timestamp   (timestamp)
  );

  crossbar xbar_i (
    .clk      (clk),
    .rst      (rst),
    .pkt_in   (pkt_tx),
    .pkt_out  (pkt_rx),
    .net_full (net_full)
  );

  packet_sink sink_i (
    .clk       (clk),
    .rst       (rst),
    .measure   (measure),
    .clear     (clear),
    .pkt_rx    (pkt_rx),
    .pkt_tx    (pkt_tx),
    .timestamp (timestamp),
    .rd_src    (rd_src),
    .rd_dst    (rd_dst),
    .rd_stats  (rd_stats)
  );

  stat_reader reader_i (
    .clk          (clk),
    .rst          (rst),
    .cmd_valid    (cmd_valid),
    .cmd          (cmd),
    .rd_src       (rd_src),
    .rd_dst       (rd_dst),
    .clear        (clear),
    .rd_stats     (rd_stats),
    .result_valid (result_valid),
    .result       (result)
  );

endmodule

`default_nettype wire

// ==== tb/noc_meter_tb.sv ====
`default_nettype none

module noc_meter_tb
  import noc_pkg::*;
  import stats_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam string cases_path      = "tb/noc_meter_cases.txt";
  localparam int    cycles_per_line = 20;
  localparam int    cycles_base     = 200;

  logic                      clk;
  logic                      rst;
  logic [num_ports-1:0]      inject;
  port_idx_t [num_ports-1:0] inject_dest;
  logic                      measure;
  logic                      cmd_valid;
  stat_cmd_t                 cmd;
  logic [num_ports-1:0]      net_full;
  logic                      result_valid;
  logic [result_w-1:0]       result;

  // reference model indexed [source][destination]
  int unsigned m_rx  [num_ports][num_ports];
  int unsigned m_tx  [num_ports][num_ports];
  int unsigned m_lat [num_ports][num_ports];
  longint      lat_sum;
  int          cycle_count;
  int          cycle_limit = 0;
  string       lines [$];

  noc_meter_top dut_i (
    .clk          (clk),
    .rst          (rst),
    .inject       (inject),
    .inject_dest  (inject_dest),
    .measure      (measure),
    .cmd_valid    (cmd_valid),
    .cmd          (cmd),
    .net_full     (net_full),
    .result_valid (result_valid),
    .result       (result)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  // ========================================
  // helpers
  // ========================================

  task automatic stop_run(string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "%s", why);
  endtask

  task automatic check_value(string name, longint expected, longint actual);
    if (expected != actual) begin
      stop_run($sformatf("FAIL %s expected %0d actual %0d", name, expected, actual));
    end
  endtask

  // next rising edge plus the drive offset
  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic load_cases();
    int    fd;
    string line;
    fd = $fopen(cases_path, "r");
    if (fd == 0) begin
      stop_run({"cannot open the case file ", cases_path});
    end else begin
      while (!$feof(fd)) begin
        line = "";
        if ($fgets(line, fd) > 0 && line.len() > 1 && line.getc(0) != "#") begin
          lines.push_back(line);
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic model_clear();
    for (int s = 0; s < num_ports; s++) begin
      for (int d = 0; d < num_ports; d++) begin
        m_rx[s][d]  = 0;
        m_tx[s][d]  = 0;
        m_lat[s][d] = 0;
      end
    end
  endtask

  function automatic longint model_value(stat_op_t op, int s, int d);
    longint total;
    total = 0;
    for (int i = 0; i < num_ports; i++) begin
      for (int j = 0; j < num_ports; j++) begin
        total += m_rx[i][j];
      end
    end
    case (op)
      op_read_rx:    return m_rx[s][d];
      op_read_tx:    return m_tx[s][d];
      op_read_lat:   return m_lat[s][d];
      op_read_total: return total;
      default:       return 0;
    endcase
  endfunction

  // last winner leaves one edge after net_full drops and is counted one edge later
  task automatic drain_network(output bit seen_full);
    seen_full = 1'b0;
    while (net_full != '0) begin
      seen_full = 1'b1;
      step();
    end
    step();
    step();
  endtask

  task automatic send_inject(logic [num_ports-1:0] mask, port_idx_t [num_ports-1:0] dests,
                             bit uncontended);
    bit seen_full;
    while ((net_full & mask) != '0) begin
      step();
    end
    inject      = mask;
    inject_dest = dests;
    step();
    inject = '0;
    if (measure) begin
      for (int p = 0; p < num_ports; p++) begin
        if (mask[p]) begin
          m_tx[p][dests[p]]++;
          m_rx[p][dests[p]]++;
          // one cycle through a free crossbar output
          if (uncontended) begin
            m_lat[p][dests[p]]++;
          end
        end
      end
    end
    drain_network(seen_full);
    // arbitration losers wait in their input buffer with net_full high
    check_value($sformatf("net_full inject %h", mask), longint'(!uncontended),
                longint'(seen_full));
  endtask

  task automatic run_command(string name, stat_op_t op, port_idx_t src, port_idx_t dst,
                             longint expected, bit accumulate);
    longint got;
    cmd_valid = 1'b1;
    cmd.op    = op;
    cmd.src   = src;
    cmd.dst   = dst;
    step();
    cmd_valid = 1'b0;
    cmd.op    = op_nop;
    check_value({name, " result_valid"}, (op != op_nop), result_valid);
    got = result;
    if (op == op_clear) begin
      model_clear();
    end
    step();
    check_value({name, " pulse width"}, 0, result_valid);
    if (accumulate) begin
      lat_sum += got;
    end else if (op != op_nop) begin
      if (expected < 0) begin
        expected = model_value(op, src, dst);
      end
      check_value(name, expected, got);
    end
  endtask

  // ========================================
  // timeout
  // ========================================

  initial begin
    cycle_count = 0;
    wait (cycle_limit > 0);
    while (cycle_count < cycle_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    stop_run($sformatf("timeout, the run did not finish within %0d cycles", cycle_limit));
  end

  // ========================================
  // case file driven stimulus
  // ========================================

  initial begin
    string                     line;
    byte                       kind;
    byte                       tag;
    int                        n;
    int                        mask;
    int                        d [num_ports];
    int                        op;
    int                        src;
    int                        dst;
    int                        level;
    longint                    expected;
    logic [8*32-1:0]           name_v;
    port_idx_t [num_ports-1:0] dests;

    rst         = 1'b1;
    inject      = '0;
    inject_dest = '0;
    measure     = 1'b0;
    cmd_valid   = 1'b0;
    cmd         = '0;
    lat_sum     = 0;
    model_clear();
    load_cases();
    cycle_limit = cycles_per_line * lines.size() + cycles_base;

    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;

    foreach (lines[i]) begin
      line = lines[i];
      kind = line.getc(0);
      case (kind)
        "i": begin
          n = $sscanf(line, "i %h %d %d %d %d %c", mask, d[0], d[1], d[2], d[3], tag);
          if (n != 6) begin
            stop_run({"malformed inject line: ", line});
          end else begin
            for (int p = 0; p < num_ports; p++) begin
              dests[p] = port_idx_t'(d[p]);
            end
            send_inject(num_ports'(mask), dests, tag == "u");
          end
        end
        "m": begin
          n = $sscanf(line, "m %d", level);
          measure = (level != 0);
          step();
        end
        "c": begin
          n = $sscanf(line, "c %s %d %d %d %d", name_v, op, src, dst, expected);
          if (n != 5) begin
            stop_run({"malformed command line: ", line});
          end else begin
            run_command($sformatf("%0s", name_v), stat_op_t'(op), port_idx_t'(src),
                        port_idx_t'(dst), expected, 1'b0);
          end
        end
        "a": begin
          n = $sscanf(line, "a %s %d %d %d", name_v, op, src, dst);
          if (n != 4) begin
            stop_run({"malformed accumulate line: ", line});
          end else begin
            run_command($sformatf("%0s", name_v), stat_op_t'(op), port_idx_t'(src),
                        port_idx_t'(dst), -1, 1'b1);
          end
        end
        "s": begin
          n = $sscanf(line, "s %s %d", name_v, expected);
          // only a lower bound holds and a short sum shows up as the actual value
          check_value($sformatf("%0s", name_v), expected,
                      (lat_sum >= expected) ? expected : lat_sum);
          lat_sum = 0;
        end
        default: begin
          stop_run({"unknown case line kind: ", line});
        end
      endcase
    end

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb/noc_meter_cases.txt ====
# i <mask hex> <dest p0> <dest p1> <dest p2> <dest p3> <u|c>  inject, u = uncontended
# m <level>  c <name> <op> <src> <dst> <expected, -1 = model>  a <name> <op> <src> <dst>
# s <name> <minimum of accumulated results>   op: 0 nop 1 rx 2 tx 3 lat 4 total 5 clear
m 1
i 1 2 0 0 0 u
i 4 0 0 3 0 u
i a 0 3 0 1 u
c rx_0_2 1 0 2 1
c tx_0_2 2 0 2 1
c lat_0_2 3 0 2 1
c lat_2_3 3 2 3 -1
c tx_1_3 2 1 3 -1
c lat_3_1 3 3 1 1
c total_single 4 0 0 4
c nop_idle 0 0 0 0
c clear_all 5 0 0 0
c rx_after_clear 1 0 2 0
c total_after_clear 4 0 0 -1
i f 2 2 2 2 c
c rx_hot_0 1 0 2 1
c rx_hot_1 1 1 2 1
c rx_hot_2 1 2 2 1
c rx_hot_3 1 3 2 -1
c total_hot 4 0 0 4
a lat_hot_0 3 0 2
a lat_hot_1 3 1 2
a lat_hot_2 3 2 2
a lat_hot_3 3 3 2
s lat_hot_sum 4
m 0
i 3 1 0 0 0 u
c rx_idle_0_1 1 0 1 0
c tx_idle_1_0 2 1 0 0
c lat_idle_0_1 3 0 1 -1
c total_idle 4 0 0 -1

// ==== files.f ====
verilog/noc_pkg.sv
verilog/stats_pkg.sv
verilog/traffic_gen.sv
verilog/crossbar.sv
verilog/packet_sink.sv
verilog/stat_reader.sv
verilog/noc_meter_top.sv
tb/noc_meter_tb.sv

// ==== Bender.yml ====
package:
  name: noc_meter

sources:
  - files:
      - verilog/noc_pkg.sv
      - verilog/stats_pkg.sv
      - verilog/traffic_gen.sv
      - verilog/crossbar.sv
      - verilog/packet_sink.sv
      - verilog/stat_reader.sv
      - verilog/noc_meter_top.sv
  - target: simulation
    files:
      - tb/noc_meter_tb.sv
